/* project.f */
+incdir+common
common/xbar_pkg.sv
source/xbar_cfg_regs.sv
xbar/xbar_master_port.sv
xbar/xbar_slave_port.sv
mem_slave/resp_fifo.sv
mem_slave/mem_slave.sv
source/xbar_top.sv
bench/xbar_checker.sv
bench/xbar_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module xbar_tb -o xbar_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/xbar_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* bench/xbar_tb.sv */
/*
 crossbar testbench
 table-driven traffic from two masters, checked against a memory model
*/
`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_tb;
	import xbar_pkg::*;
	localparam int MAXE = 64;

	logic clk_i, rst_i, cfg_we;
	logic [`XBAR_CFG_AW-1:0] cfg_addr;
	logic [`XBAR_DW-1:0] cfg_wdata;
	logic req_d [2];
	logic [`XBAR_DW-1:0] addr_d [2];
	bus_cmd_e cmd_d [2];
	logic [`XBAR_DW-1:0] wdata_d [2];
	logic ack_w [2];
	logic resp_w [2];
	logic [`XBAR_DW-1:0] rdata_w [2];

	// stimulus table, expected value used where t_has_exp is set
	int t_phase [MAXE];
	int t_m [MAXE];
	bus_cmd_e t_cmd [MAXE];
	logic [`XBAR_DW-1:0] t_addr [MAXE], t_wdata [MAXE], t_exp [MAXE];
	bit t_has_exp [MAXE];
	int n_ent = 0;

	logic [`XBAR_DW-1:0] model [2][`XBAR_MEM_WORDS];   // reference memory per slave
	logic [`XBAR_DW-1:0] exp_q [2][$];                 // expected reads per master
	int ack_seq [$];                                   // master order of acks in a phase
	int last_ack [2];
	int cyc = 0, limit = 100000, errors = 0, checks = 0, cur_phase = 0;

	xbar_top UUT (.clk_i, .rst_i, .cfg_we, .cfg_addr, .cfg_wdata,
		.m0_req(req_d[0]), .m0_addr(addr_d[0]), .m0_cmd(cmd_d[0]), .m0_wdata(wdata_d[0]),
		.m0_ack(ack_w[0]), .m0_resp(resp_w[0]), .m0_rdata(rdata_w[0]),
		.m1_req(req_d[1]), .m1_addr(addr_d[1]), .m1_cmd(cmd_d[1]), .m1_wdata(wdata_d[1]),
		.m1_ack(ack_w[1]), .m1_resp(resp_w[1]), .m1_rdata(rdata_w[1]));

	initial
	begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	always @(posedge clk_i)
	begin
		cyc <= cyc + 1;
		if (cyc >= limit)
		begin
			$display("timeout: run stopped after %0d cycles with traffic still pending", cyc);
			$display("TEST FAILED");
			$finish;
		end
	end

	// responses compared in issue order, sampled mid-cycle
	always @(negedge clk_i)
	begin
		for (int m = 0; m < 2; m++)
		begin
			if (!rst_i && resp_w[m])
			begin
				checks++;
				if (exp_q[m].size() == 0)
				begin
					$display("master %0d got a response with no read pending", m);
					errors++;
				end
				else if (rdata_w[m] !== exp_q[m][0])
				begin
					$display("Fail %0t: master %0d rdata %h expected %h", $time, m,
						rdata_w[m], exp_q[m][0]);
					errors++;
				end
				if (exp_q[m].size() != 0)
					void'(exp_q[m].pop_front());
				if (cur_phase == 2 && cyc != last_ack[m] + 1)
				begin
					$display("Fail %0t: master %0d resp not one cycle after ack", $time, m);
					errors++;
				end
			end
		end
	end

	task automatic add(input int ph, input int m, input bus_cmd_e c, input int s, input int w,
		input logic [`XBAR_DW-1:0] wd, input bit he, input logic [`XBAR_DW-1:0] ex);
		t_phase[n_ent] = ph;
		t_m[n_ent] = m;
		t_cmd[n_ent] = c;
		t_addr[n_ent] = (s << `XBAR_SLV_SEL_BIT) | (w << 2);
		t_wdata[n_ent] = wd;
		t_has_exp[n_ent] = he;
		t_exp[n_ent] = ex;
		n_ent++;
	endtask

	// one request, starts 2 ns after a rising edge and returns at the same point
	task automatic issue(input int i, input bit lone);
		int m;
		int waited;
		int s;
		int w;
		m = t_m[i];
		waited = 0;
		s = t_addr[i][`XBAR_SLV_SEL_BIT];
		w = t_addr[i][9:2];
		req_d[m] = 1'b1;
		addr_d[m] = t_addr[i];
		cmd_d[m] = t_cmd[i];
		wdata_d[m] = t_wdata[i];
		@(negedge clk_i);
		while (!ack_w[m])
		begin
			waited++;
			@(negedge clk_i);
		end
		ack_seq.push_back(m);
		last_ack[m] = cyc;
		if (t_cmd[i] == CMD_WRITE)
			model[s][w] = t_wdata[i];
		else if (t_has_exp[i])
			exp_q[m].push_back(t_exp[i]);      // value fixed by the table
		else
			exp_q[m].push_back(model[s][w]);   // memory state at the accepting edge
		if (lone && waited != 0)
		begin
			$display("Fail %0t: master %0d ack %0d cycles after req", $time, m, waited);
			errors++;
		end
		@(posedge clk_i);
		#2;
		req_d[m] = 1'b0;
		if (lone)
		begin
			while (exp_q[m].size() != 0)
			begin
				@(posedge clk_i);
				#2;
			end
		end
	endtask

	task automatic run_master(input int m, input int ph, input bit lone);
		for (int i = 0; i < n_ent; i++)
			if (t_phase[i] == ph && t_m[i] == m)
				issue(i, lone);
	endtask

	task automatic run_phase(input int ph, input bit lone);
		ack_seq.delete();
		cur_phase = ph;
		if (lone)
		begin
			run_master(0, ph, 1'b1);
			run_master(1, ph, 1'b1);
		end
		else
			fork
				run_master(0, ph, 1'b0);
				run_master(1, ph, 1'b0);
			join
		while (exp_q[0].size() != 0 || exp_q[1].size() != 0)   // drain reads
		begin
			@(posedge clk_i);
			#2;
		end
		$display("phase %0d done, %0d acks, errors so far %0d", ph, ack_seq.size(), errors);
	endtask

	task automatic cfg_write(input int a, input int d);
		cfg_we = 1'b1;
		cfg_addr = a;
		cfg_wdata = d;
		@(posedge clk_i);
		#2;
		cfg_we = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'h8a65_34f1));
		rst_i = 1'b1;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		for (int m = 0; m < 2; m++)
		begin
			req_d[m] = 1'b0;
			addr_d[m] = '0;
			cmd_d[m] = CMD_READ;
			wdata_d[m] = '0;
			last_ack[m] = 0;
		end
		for (int s = 0; s < 2; s++)
			for (int w = 0; w < `XBAR_MEM_WORDS; w++)
				model[s][w] = `XBAR_MEM_FILL;
		// reset fill on both slaves
		add(1, 0, CMD_READ, 0, 5, '0, 1, `XBAR_MEM_FILL);
		add(1, 0, CMD_READ, 1, 200, '0, 1, `XBAR_MEM_FILL);
		add(1, 1, CMD_READ, 0, 77, '0, 1, `XBAR_MEM_FILL);
		add(1, 1, CMD_READ, 1, 255, '0, 1, `XBAR_MEM_FILL);
		// write and read-back, each master alone
		for (int m = 0; m < 2; m++)
			for (int s = 0; s < 2; s++)
				add(2, m, CMD_WRITE, s, 10 + m * 10, $urandom, 0, '0);
		for (int m = 0; m < 2; m++)
			for (int s = 0; s < 2; s++)
				add(2, m, CMD_READ, s, 10 + m * 10, '0, 0, '0);
		// same slave contention, fixed then round robin
		for (int m = 0; m < 2; m++)
			add(3, m, CMD_WRITE, 0, 50 + m, $urandom, 0, '0);
		for (int k = 0; k < 6; k++)
			add(4, k % 2, CMD_WRITE, 0, 60 + k, $urandom, 0, '0);
		// ordering across slaves with slave 0 slowed down
		add(5, 0, CMD_READ, 0, 10, '0, 0, '0);
		add(5, 0, CMD_READ, 1, 10, '0, 0, '0);
		add(5, 0, CMD_READ, 0, 5, '0, 1, `XBAR_MEM_FILL);
		// mixed throttled traffic, each master on its own words
		for (int k = 0; k < 16; k++)
			add(6, k % 2, bus_cmd_e'($urandom_range(0, 1)), $urandom_range(0, 1),
				64 + (k % 2) * 16 + $urandom_range(0, 7), $urandom, 0, '0);
		limit = 64 * n_ent + 200;
		repeat (2) @(posedge clk_i);
		#2;
		rst_i = 1'b0;
		run_phase(1, 1'b0);
		run_phase(2, 1'b1);
		run_phase(3, 1'b0);
		checks++;
		if (ack_seq[0] != 0)
		begin
			$display("Fail %0t: master 1 won under fixed priority", $time);
			errors++;
		end
		cfg_write(`XBAR_CFG_ARB, ARB_RR);
		run_phase(4, 1'b0);
		for (int k = 1; k < ack_seq.size(); k++)
		begin
			checks++;
			if (ack_seq[k] == ack_seq[k - 1])
			begin
				$display("Fail %0t: round robin gave master %0d two acks in a row", $time,
					ack_seq[k]);
				errors++;
			end
		end
		cfg_write(`XBAR_CFG_THR0, 3);
		run_phase(5, 1'b0);
		cfg_write(`XBAR_CFG_THR0, 2);
		cfg_write(`XBAR_CFG_THR1, 3);
		run_phase(6, 1'b0);
		$display("%0d entries, %0d checks, %0d errors", n_ent, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* bench/xbar_checker.sv */
/*
 crossbar protocol checker
 bound into master and slave ports, handshake and grant assertions
*/
`timescale 1ns/1ps

module xbar_checker
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic [1:0] req,      // per master request, both bits equal on a master port
	input  logic [1:0] ack,
	input  logic resp,
	input  logic resp_ok,        // some read is outstanding
	input  logic [1:0] gnt,      // grants, one-hot or zero
	input  logic [33:0] hold,    // request fields that must not move while waiting
	input  logic hold_chk
);

	// an ack never comes without its request
	ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
		(ack & ~req) == 2'b00)
		else $error("ack without request");

	// resp only answers a read already accepted
	resp_needs_read: assert property (@(posedge clk_i) disable iff (rst_i)
		resp |-> resp_ok)
		else $error("resp with no outstanding read");

	// never two masters on one slave
	one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0(gnt))
		else $error("more than one grant");

	// master holds req, cmd and addr until ack
	req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		(hold_chk && req[0] && !ack[0]) |=> $stable(hold))
		else $error("request changed before ack");

endmodule

bind xbar_master_port xbar_checker u_chk_mp (
	.clk_i, .rst_i,
	.req({req, req}), .ack({ack, ack}),
	.resp, .resp_ok(rd_cnt != '0),
	.gnt({ack_s1, ack_s0}),
	.hold({req, cmd, addr}), .hold_chk(1'b1)
);

bind xbar_slave_port xbar_checker u_chk_sp (
	.clk_i, .rst_i,
	.req({req_m1, req_m0}), .ack({ack_m1, ack_m0}),
	.resp(slave_resp), .resp_ok(~id_empty),
	.gnt({gnt_m1, gnt_m0}),
	.hold('0), .hold_chk(1'b0)
);

/* source/xbar_top.sv */
/*
 two-master two-slave crossbar
 master ports, slave ports with arbiters, memory slaves and config block
*/
`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_top
(
	input  logic clk_i,
	input  logic rst_i,

	input  logic cfg_we,
	input  logic [`XBAR_CFG_AW-1:0] cfg_addr,
	input  logic [`XBAR_DW-1:0] cfg_wdata,

	input  logic m0_req,
	input  logic [`XBAR_DW-1:0] m0_addr,
	input  xbar_pkg::bus_cmd_e m0_cmd,
	input  logic [`XBAR_DW-1:0] m0_wdata,
	output logic m0_ack,
	output logic m0_resp,
	output logic [`XBAR_DW-1:0] m0_rdata,

	input  logic m1_req,
	input  logic [`XBAR_DW-1:0] m1_addr,
	input  xbar_pkg::bus_cmd_e m1_cmd,
	input  logic [`XBAR_DW-1:0] m1_wdata,
	output logic m1_ack,
	output logic m1_resp,
	output logic [`XBAR_DW-1:0] m1_rdata
);

	import xbar_pkg::*;

	arb_mode_e arb_mode;
	logic [`XBAR_THR_W-1:0] thr0;
	logic [`XBAR_THR_W-1:0] thr1;

	// master n to slave k handshakes, named _m<n>_s<k>
	logic req_m0_s0, req_m0_s1, req_m1_s0, req_m1_s1;
	logic ack_m0_s0, ack_m0_s1, ack_m1_s0, ack_m1_s1;
	logic resp_m0_s0, resp_m0_s1, resp_m1_s0, resp_m1_s1;
	logic [`XBAR_DW-1:0] rdata_s0;
	logic [`XBAR_DW-1:0] rdata_s1;

	// slave buses toward the memories
	logic s0_req, s0_ack, s0_resp;
	logic s1_req, s1_ack, s1_resp;
	logic [`XBAR_DW-1:0] s0_addr, s0_wdata, s0_rdata;
	logic [`XBAR_DW-1:0] s1_addr, s1_wdata, s1_rdata;
	bus_cmd_e s0_cmd;
	bus_cmd_e s1_cmd;

	xbar_cfg_regs u_cfg (.clk_i, .rst_i, .cfg_we, .cfg_addr, .cfg_wdata,
		.arb_mode, .thr0, .thr1);

	xbar_master_port u_mp0 (.clk_i, .rst_i, .req(m0_req), .addr(m0_addr), .cmd(m0_cmd),
		.ack(m0_ack), .resp(m0_resp), .rdata(m0_rdata), .sel(),
		.req_s0(req_m0_s0), .req_s1(req_m0_s1), .ack_s0(ack_m0_s0), .ack_s1(ack_m0_s1),
		.resp_s0(resp_m0_s0), .resp_s1(resp_m0_s1), .rdata_s0(rdata_s0), .rdata_s1(rdata_s1));

	xbar_master_port u_mp1 (.clk_i, .rst_i, .req(m1_req), .addr(m1_addr), .cmd(m1_cmd),
		.ack(m1_ack), .resp(m1_resp), .rdata(m1_rdata), .sel(),
		.req_s0(req_m1_s0), .req_s1(req_m1_s1), .ack_s0(ack_m1_s0), .ack_s1(ack_m1_s1),
		.resp_s0(resp_m1_s0), .resp_s1(resp_m1_s1), .rdata_s0(rdata_s0), .rdata_s1(rdata_s1));

	// address, cmd and wdata go straight from the masters to both slave ports
	xbar_slave_port u_sp0 (.clk_i, .rst_i, .arb_mode,
		.req_m0(req_m0_s0), .addr_m0(m0_addr), .cmd_m0(m0_cmd), .wdata_m0(m0_wdata),
		.req_m1(req_m1_s0), .addr_m1(m1_addr), .cmd_m1(m1_cmd), .wdata_m1(m1_wdata),
		.ack_m0(ack_m0_s0), .ack_m1(ack_m1_s0), .resp_m0(resp_m0_s0), .resp_m1(resp_m1_s0),
		.rdata(rdata_s0), .slave_req(s0_req), .slave_addr(s0_addr), .slave_cmd(s0_cmd),
		.slave_wdata(s0_wdata), .slave_ack(s0_ack), .slave_resp(s0_resp),
		.slave_rdata(s0_rdata));

	xbar_slave_port u_sp1 (.clk_i, .rst_i, .arb_mode,
		.req_m0(req_m0_s1), .addr_m0(m0_addr), .cmd_m0(m0_cmd), .wdata_m0(m0_wdata),
		.req_m1(req_m1_s1), .addr_m1(m1_addr), .cmd_m1(m1_cmd), .wdata_m1(m1_wdata),
		.ack_m0(ack_m0_s1), .ack_m1(ack_m1_s1), .resp_m0(resp_m0_s1), .resp_m1(resp_m1_s1),
		.rdata(rdata_s1), .slave_req(s1_req), .slave_addr(s1_addr), .slave_cmd(s1_cmd),
		.slave_wdata(s1_wdata), .slave_ack(s1_ack), .slave_resp(s1_resp),
		.slave_rdata(s1_rdata));

	mem_slave #(.LFSR_SEED(16'hace1)) u_mem0 (.clk_i, .rst_i, .thr(thr0),
		.slave_req(s0_req), .slave_addr(s0_addr), .slave_cmd(s0_cmd), .slave_wdata(s0_wdata),
		.slave_ack(s0_ack), .slave_resp(s0_resp), .slave_rdata(s0_rdata));

	mem_slave #(.LFSR_SEED(16'h5a3c)) u_mem1 (.clk_i, .rst_i, .thr(thr1),
		.slave_req(s1_req), .slave_addr(s1_addr), .slave_cmd(s1_cmd), .slave_wdata(s1_wdata),
		.slave_ack(s1_ack), .slave_resp(s1_resp), .slave_rdata(s1_rdata));

endmodule

/* mem_slave/mem_slave.sv */
/*
 memory slave
 word memory filled on reset, LFSR-throttled ack and resp, read data FIFO
*/
`timescale 1ns/1ps
`include "xbar_defines.svh"

module mem_slave
#(
	parameter logic [15:0] LFSR_SEED = 16'hace1    // must be nonzero
)
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic [`XBAR_THR_W-1:0] thr,            // 0 means no throttling

	input  logic slave_req,
	input  logic [`XBAR_DW-1:0] slave_addr,
	input  xbar_pkg::bus_cmd_e slave_cmd,
	input  logic [`XBAR_DW-1:0] slave_wdata,
	output logic slave_ack,
	output logic slave_resp,
	output logic [`XBAR_DW-1:0] slave_rdata
);

	import xbar_pkg::*;

	localparam int IDX_W = $clog2(`XBAR_MEM_WORDS);
	localparam int MSK_W = (1 << `XBAR_THR_W) - 1;   // widest mask for max rate

	logic [`XBAR_DW-1:0] mem [`XBAR_MEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [`XBAR_DW-1:0] rd_word;
	logic [15:0] lfsr;
	logic [MSK_W-1:0] thr_mask;
	logic ack_en;
	logic resp_en;
	logic fifo_wr;
	logic fifo_full;
	logic fifo_empty;

	assign idx = slave_addr[IDX_W+1:2];    // word address
	assign rd_word = mem[idx];             // asynchronous read

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < `XBAR_MEM_WORDS; i++)
				mem[i] <= `XBAR_MEM_FILL;
		end
		else if (slave_req && slave_ack && slave_cmd == CMD_WRITE)
			mem[idx] <= slave_wdata;
	end

	// low thr bits set, enable when the matching LFSR bits are all zero
	assign thr_mask = MSK_W'((1 << thr) - 1);

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			lfsr <= LFSR_SEED;
			ack_en <= 1'b0;     // both enables off in first cycle after reset
			resp_en <= 1'b0;
		end
		else
		begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			ack_en <= (lfsr[MSK_W-1:0] & thr_mask) == '0;
			// top bits so resp is not a copy of ack
			resp_en <= (lfsr[15 -: MSK_W] & thr_mask) == '0;
		end
	end

	assign slave_ack = slave_req & ack_en & ~fifo_full;
	assign slave_resp = resp_en & ~fifo_empty;
	assign fifo_wr = slave_ack & (slave_cmd == CMD_READ);   // queue word on read ack

	resp_fifo #(
		.WIDTH(`XBAR_DW),
		.DEPTH_LOG2(`XBAR_FIFO_DEPTH_LOG2)
	) u_rdata_fifo (
		.clk_i,
		.rst_i,
		.wr(fifo_wr),
		.w_data(rd_word),
		.rd(slave_resp),
		.r_data(slave_rdata),
		.full(fifo_full),
		.empty(fifo_empty)
	);

endmodule

/* mem_slave/resp_fifo.sv */
/*
 response FIFO
 pointer-based circular buffer, head entry always visible on r_data
*/
`timescale 1ns/1ps

module resp_fifo
#(
	parameter int WIDTH = 32,
	parameter int DEPTH_LOG2 = 4
)
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic wr,
	input  logic [WIDTH-1:0] w_data,
	input  logic rd,
	output logic [WIDTH-1:0] r_data,
	output logic full,
	output logic empty
);

	logic [WIDTH-1:0] buf_mem [1 << DEPTH_LOG2];
	logic [DEPTH_LOG2:0] wr_ptr;    // extra bit tells full from empty
	logic [DEPTH_LOG2:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr & ~full;      // writes into a full FIFO are dropped
	assign do_rd = rd & ~empty;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
		(wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);
	assign r_data = buf_mem[rd_ptr[DEPTH_LOG2-1:0]];   // show-ahead head

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (do_wr)
			buf_mem[wr_ptr[DEPTH_LOG2-1:0]] <= w_data;
	end

endmodule

/* xbar/xbar_slave_port.sv */
/*
 crossbar slave port
 arbitrates the two masters onto one slave and steers read responses back
*/
`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_slave_port
(
	input  logic clk_i,
	input  logic rst_i,
	input  xbar_pkg::arb_mode_e arb_mode,

	// master 0 request
	input  logic req_m0,
	input  logic [`XBAR_DW-1:0] addr_m0,
	input  xbar_pkg::bus_cmd_e cmd_m0,
	input  logic [`XBAR_DW-1:0] wdata_m0,

	// master 1 request
	input  logic req_m1,
	input  logic [`XBAR_DW-1:0] addr_m1,
	input  xbar_pkg::bus_cmd_e cmd_m1,
	input  logic [`XBAR_DW-1:0] wdata_m1,

	output logic ack_m0,
	output logic ack_m1,
	output logic resp_m0,
	output logic resp_m1,
	output logic [`XBAR_DW-1:0] rdata,      // shared, qualified by resp

	// slave bus
	output logic slave_req,
	output logic [`XBAR_DW-1:0] slave_addr,
	output xbar_pkg::bus_cmd_e slave_cmd,
	output logic [`XBAR_DW-1:0] slave_wdata,
	input  logic slave_ack,
	input  logic slave_resp,
	input  logic [`XBAR_DW-1:0] slave_rdata
);

	import xbar_pkg::*;

	logic rr_ptr;     // master with priority next under round robin
	logic prio;       // 1 gives master 1 priority
	logic gnt_m0;
	logic gnt_m1;
	logic id_push;
	logic id_head;    // master owning the oldest pending read
	logic id_empty;   // no read pending on this slave

	assign prio = (arb_mode == ARB_RR) & rr_ptr;
	assign gnt_m0 = req_m0 & (~req_m1 | ~prio);
	assign gnt_m1 = req_m1 & (~req_m0 | prio);

	// winner's request onto the slave bus
	assign slave_req = gnt_m0 | gnt_m1;
	assign slave_addr = gnt_m1 ? addr_m1 : addr_m0;
	assign slave_cmd = gnt_m1 ? cmd_m1 : cmd_m0;
	assign slave_wdata = gnt_m1 ? wdata_m1 : wdata_m0;

	assign ack_m0 = slave_ack & gnt_m0;
	assign ack_m1 = slave_ack & gnt_m1;

	// responses follow the ID FIFO head
	assign resp_m0 = slave_resp & ~id_head;
	assign resp_m1 = slave_resp & id_head;
	assign rdata = slave_rdata;

	// pointer steps past the master just served
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			rr_ptr <= 1'b0;
		else if (slave_ack)
			rr_ptr <= gnt_m0;
	end

	// same depth and same push/pop edges as the slave's data FIFO
	assign id_push = slave_ack & (slave_cmd == CMD_READ);

	resp_fifo #(
		.WIDTH(1),
		.DEPTH_LOG2(`XBAR_FIFO_DEPTH_LOG2)
	) u_id_fifo (
		.clk_i,
		.rst_i,
		.wr(id_push),
		.w_data(gnt_m1),          // ID of the winning master
		.rd(slave_resp),
		.r_data(id_head),
		.full(),
		.empty(id_empty)
	);

endmodule

/* xbar/xbar_master_port.sv */
/*
 crossbar master port
 decodes target slave, tracks outstanding reads, merges responses
*/
`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_master_port
(
	input  logic clk_i,
	input  logic rst_i,

	// master side
	input  logic req,
	input  logic [`XBAR_DW-1:0] addr,
	input  xbar_pkg::bus_cmd_e cmd,
	output logic ack,
	output logic resp,
	output logic [`XBAR_DW-1:0] rdata,

	// slave port side
	output logic sel,                       // decoded target slave
	output logic req_s0,
	output logic req_s1,
	input  logic ack_s0,
	input  logic ack_s1,
	input  logic resp_s0,
	input  logic resp_s1,
	input  logic [`XBAR_DW-1:0] rdata_s0,
	input  logic [`XBAR_DW-1:0] rdata_s1
);

	import xbar_pkg::*;

	// enough for a full ID FIFO of reads on one slave
	localparam int CNT_W = `XBAR_FIFO_DEPTH_LOG2 + 1;

	logic [CNT_W-1:0] rd_cnt;   // reads acked, resp not yet seen
	logic rd_sel;               // slave those reads went to
	logic blocked;
	logic rd_acc;

	assign sel = addr[`XBAR_SLV_SEL_BIT];

	// switching slave with reads in flight could reorder responses
	assign blocked = (rd_cnt != '0) && (sel != rd_sel);
	assign req_s0 = req & ~sel & ~blocked;
	assign req_s1 = req & sel & ~blocked;

	assign ack = ack_s0 | ack_s1;           // only the requested slave can ack
	assign rd_acc = ack & (cmd == CMD_READ);

	// outstanding reads all sit on one slave, so never both resp at once
	assign resp = resp_s0 | resp_s1;
	assign rdata = resp_s1 ? rdata_s1 : rdata_s0;

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			rd_cnt <= '0;
			rd_sel <= 1'b0;
		end
		else
		begin
			if (rd_acc)
				rd_sel <= sel;
			case ({rd_acc, resp})
				2'b10: rd_cnt <= rd_cnt + 1'b1;
				2'b01: rd_cnt <= rd_cnt - 1'b1;
				default: rd_cnt <= rd_cnt;  // none or both, count holds
			endcase
		end
	end

endmodule

/* source/xbar_cfg_regs.sv */
/*
 crossbar configuration block
 holds arbitration mode and slave throttle rates, written by single-cycle strobe
*/
`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_cfg_regs
(
	input  logic clk_i,
	input  logic rst_i,

	// config write strobe
	input  logic cfg_we,
	input  logic [`XBAR_CFG_AW-1:0] cfg_addr,
	input  logic [`XBAR_DW-1:0] cfg_wdata,

	output xbar_pkg::arb_mode_e arb_mode,
	output logic [`XBAR_THR_W-1:0] thr0,    // slave 0 throttle
	output logic [`XBAR_THR_W-1:0] thr1     // slave 1 throttle
);

	import xbar_pkg::*;

	// one register updated per strobe, value seen from next cycle
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			arb_mode <= ARB_FIXED;     // master 0 wins by default
			thr0 <= '0;                // no throttling
			thr1 <= '0;
		end
		else if (cfg_we)
		begin
			case (cfg_addr)
				`XBAR_CFG_ARB:
					arb_mode <= arb_mode_e'(cfg_wdata[0]);
				`XBAR_CFG_THR0:
					thr0 <= cfg_wdata[`XBAR_THR_W-1:0];
				`XBAR_CFG_THR1:
					thr1 <= cfg_wdata[`XBAR_THR_W-1:0];
				default:
				begin
					// unknown address, nothing changes
				end
			endcase
		end
	end

endmodule

/* common/xbar_pkg.sv */
/*
 crossbar types
 bus command and arbitration mode encodings
*/
package xbar_pkg;

	// bus command, write is 1 as on the slave bus of the memory model
	typedef enum logic
	{
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} bus_cmd_e;

	// slave port arbitration
	typedef enum logic
	{
		ARB_FIXED = 1'b0, // master 0 always wins
		ARB_RR    = 1'b1  // round robin between masters
	} arb_mode_e;

endpackage

/* common/xbar_defines.svh */
/*
 crossbar parameters
 widths, memory size, slave decode, FIFO depth and config map
*/
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// bus widths, data and address share one width
`define XBAR_DW 32

// memory slave geometry
`define XBAR_MEM_WORDS 256        // words per slave, index from addr[9:2]
`define XBAR_SLV_SEL_BIT 12       // address bit picking slave 0 or 1
`define XBAR_MEM_FILL 32'hdeadbeef

// response FIFOs, 16 entries
`define XBAR_FIFO_DEPTH_LOG2 4

// config register map
`define XBAR_CFG_AW 2
`define XBAR_CFG_ARB 0            // arbitration mode
`define XBAR_CFG_THR0 1           // throttle rate of slave 0
`define XBAR_CFG_THR1 2           // throttle rate of slave 1

`define XBAR_THR_W 2              // throttle rate 0..3

`endif
